// File: dual_issue.f
+incdir+common
common/issue_pkg.sv
source/pipe_reg.sv
source/pair_decode.sv
issue/hazard_check.sv
issue/issue_stage.sv
source/dual_issue.sv
tests/dual_issue_checker.sv
tests/dual_issue_monitor.sv
tests/dual_issue_tb.sv

// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f dual_issue.f --top-module dual_issue_tb -Mdir obj_dir

run: build
	./obj_dir/Vdual_issue_tb | tee sim.log
	grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing -f dual_issue.f --top-module dual_issue_tb

clean:
	rm -rf obj_dir sim.log

// File: tests/dual_issue_tb.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module dual_issue_tb;

  localparam int ROWS = 10;

  logic                   clk;
  logic                   arst_n;
  logic                   flush;
  logic                   in_valid;
  logic                   in_ready;
  logic [`INST_WIDTH-1:0] inst0;
  logic [`INST_WIDTH-1:0] inst1;
  logic [`ADDR_WIDTH-1:0] pc0;
  logic [`ADDR_WIDTH-1:0] pc1;
  logic [`ID_WIDTH-1:0]   id0;
  logic [`ID_WIDTH-1:0]   id1;
  logic                   out_valid;
  logic                   out_ready;
  logic                   lane0_valid;
  logic [`INST_WIDTH-1:0] lane0_inst;
  logic [`ADDR_WIDTH-1:0] lane0_pc;
  logic [`ID_WIDTH-1:0]   lane0_id;
  logic                   lane1_valid;
  logic [`INST_WIDTH-1:0] lane1_inst;
  logic [`ADDR_WIDTH-1:0] lane1_pc;
  logic [`ID_WIDTH-1:0]   lane1_id;

  logic [8*12-1:0]        test_name;
  logic [1:0]             exp_count;
  logic [11:0]            exp_code;
  logic                   test_start;
  logic                   test_done;
  logic                   stall_out;
  logic                   timed_out;
  int                     got;
  int                     pass_count;
  int                     fail_count;
  integer                 seed;

  // table rows: name, inst0, inst1, bundle count, bundle codes, flush.
  // bundle code nibble is {lane0 valid, lane0 slot, lane1 valid, lane1 slot}.
  logic [8*12-1:0]        row_name [ROWS];
  logic [`INST_WIDTH-1:0] row_inst0 [ROWS];
  logic [`INST_WIDTH-1:0] row_inst1 [ROWS];
  logic [1:0]             row_count [ROWS];
  logic [11:0]            row_code [ROWS];
  logic                   row_flush [ROWS];

  dual_issue dut_i (.*);

  dual_issue_monitor monitor_i (.*);

  function automatic logic [31:0] enc(input logic [5:0] op, input int rs, input int rt,
                                      input int rd);
    return {op, rs[4:0], rt[4:0], rd[4:0], 11'd0};
  endfunction

  task automatic set_row(input int i, input logic [8*12-1:0] name, input logic [31:0] a,
                         input logic [31:0] b, input logic [1:0] n, input logic [11:0] code,
                         input logic fl);
    row_name[i] = name;
    row_inst0[i] = a;
    row_inst1[i] = b;
    row_count[i] = n;
    row_code[i] = code;
    row_flush[i] = fl;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) begin
    out_ready <= stall_out ? 1'b0 : 1'($random(seed));
  end

  ////////////////////////////////////////
  // stimulus

  task automatic send_pair();
    int i;
    in_valid = 1'b1;
    for (i = 0; i < 200; i++) begin
      if (in_ready) begin
        break;
      end
      @(negedge clk);
    end
    if (!in_ready) begin
      $display("timeout waiting for in_ready in test %0s", test_name);
      timed_out = 1'b1;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic wait_bundles();
    int i;
    for (i = 0; i < 200 && got != int'(exp_count); i++) begin
      @(negedge clk);
    end
    if (got != int'(exp_count)) begin
      $display("timeout waiting for output bundles in test %0s", test_name);
      timed_out = 1'b1;
    end
  endtask

  task automatic flush_held();
    int i;
    for (i = 0; i < 200 && !out_valid; i++) begin
      @(negedge clk);
    end
    if (!out_valid) begin
      $display("timeout waiting for the split head in test %0s", test_name);
      timed_out = 1'b1;
    end
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    stall_out = 1'b0;
  endtask

  initial begin
    seed = 78;
    {arst_n, flush, in_valid, out_ready, stall_out, timed_out} = '0;
    {inst0, inst1, pc0, pc1, id0, id1} = '0;
    {test_name, exp_count, exp_code, test_start, test_done} = '0;
    set_row(0, "alu_pair", enc(6'h01, 1, 2, 3), enc(6'h02, 4, 5, 6), 2'd1, 12'h00B, 0);
    set_row(1, "mem_alu", enc(6'h21, 1, 2, 0), enc(6'h01, 4, 5, 3), 2'd1, 12'h00E, 0);
    set_row(2, "dep_pair", enc(6'h01, 1, 2, 5), enc(6'h02, 5, 3, 6), 2'd2, 12'h0C8, 0);
    set_row(3, "two_branch", enc(6'h30, 0, 0, 0), enc(6'h32, 0, 0, 0), 2'd2, 12'h0C8, 0);
    set_row(4, "two_memory", enc(6'h21, 1, 2, 0), enc(6'h22, 0, 0, 0), 2'd2, 12'h032, 0);
    set_row(5, "mem_branch", enc(6'h22, 0, 0, 0), enc(6'h30, 0, 0, 0), 2'd1, 12'h00E, 0);
    set_row(6, "load", enc(6'h20, 1, 7, 0), enc(6'h01, 2, 3, 8), 2'd1, 12'h00E, 0);
    set_row(7, "load_use", enc(6'h01, 7, 2, 9), enc(6'h02, 3, 4, 10), 2'd2, 12'h0B0, 0);
    set_row(8, "flush_held", enc(6'h01, 1, 2, 5), enc(6'h02, 5, 3, 6), 2'd0, 12'h000, 1);
    set_row(9, "after_flush", enc(6'h01, 1, 2, 3), enc(6'h02, 4, 5, 6), 2'd1, 12'h00B, 0);
    repeat (5) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    for (int r = 0; r < ROWS && !timed_out; r++) begin
      test_name = row_name[r];
      inst0 = row_inst0[r];
      inst1 = row_inst1[r];
      pc0 = 16'h0100 + 16'(r * 8);
      pc1 = pc0 + 16'd4;
      id0 = 4'(2 * r);
      id1 = 4'(2 * r + 1);
      exp_count = row_count[r];
      exp_code = row_code[r];
      stall_out = row_flush[r]; // head and tail both held back.
      test_start = 1'b1;
      @(negedge clk);
      test_start = 1'b0;
      send_pair();
      if (row_flush[r]) begin
        flush_held();
      end
      wait_bundles();
      test_done = 1'b1;
      @(negedge clk);
      test_done = 1'b0;
    end
    $display("tests: %0d passed, %0d failed, %0d assertion failures",
             pass_count, fail_count, dut_i.checker_i.assert_errors);
    if (!timed_out && fail_count == 0 && pass_count == ROWS &&
        dut_i.checker_i.assert_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: tests/dual_issue_monitor.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module dual_issue_monitor (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   out_valid,
  input  logic                   out_ready,
  input  logic                   lane0_valid,
  input  logic [`INST_WIDTH-1:0] lane0_inst,
  input  logic [`ADDR_WIDTH-1:0] lane0_pc,
  input  logic [`ID_WIDTH-1:0]   lane0_id,
  input  logic                   lane1_valid,
  input  logic [`INST_WIDTH-1:0] lane1_inst,
  input  logic [`ADDR_WIDTH-1:0] lane1_pc,
  input  logic [`ID_WIDTH-1:0]   lane1_id,
  input  logic [`INST_WIDTH-1:0] inst0,
  input  logic [`INST_WIDTH-1:0] inst1,
  input  logic [`ADDR_WIDTH-1:0] pc0,
  input  logic [`ADDR_WIDTH-1:0] pc1,
  input  logic [`ID_WIDTH-1:0]   id0,
  input  logic [`ID_WIDTH-1:0]   id1,
  input  logic [8*12-1:0]        test_name,
  input  logic [1:0]             exp_count,
  input  logic [11:0]            exp_code,
  input  logic                   test_start,
  input  logic                   test_done,
  output int                     got,
  output int                     pass_count,
  output int                     fail_count
);

  localparam int LANE_BITS = 1 + `INST_WIDTH + `ADDR_WIDTH + `ID_WIDTH;

  logic                 bad;
  logic [3:0]           code;
  logic [LANE_BITS-1:0] exp0;
  logic [LANE_BITS-1:0] exp1;
  logic [LANE_BITS-1:0] act0;
  logic [LANE_BITS-1:0] act1;

  // unused lane is expected all zero.
  function automatic logic [LANE_BITS-1:0] lane_word(input logic v, input logic s);
    return v ? {1'b1, s ? inst1 : inst0, s ? pc1 : pc0, s ? id1 : id0} : '0;
  endfunction

  assign act0 = {lane0_valid, lane0_inst, lane0_pc, lane0_id};
  assign act1 = {lane1_valid, lane1_inst, lane1_pc, lane1_id};

  initial begin
    got = 0;
    pass_count = 0;
    fail_count = 0;
    bad = 1'b0;
  end

  always @(posedge clk) begin
    if (test_start) begin
      got <= 0;
      bad = 1'b0;
      if (out_valid && out_ready) begin
        $display("test %0s saw a bundle arrive before it started", test_name);
        bad = 1'b1;
      end
    end else if (arst_n) begin
      if (out_valid && out_ready) begin
        if (got >= int'(exp_count)) begin
          $display("test %0s received a bundle it should not produce", test_name);
          bad = 1'b1;
        end else begin
          code = exp_code[4*got +: 4];
          exp0 = lane_word(code[3], code[2]);
          exp1 = lane_word(code[1], code[0]);
          if (act0 != exp0 || act1 != exp1) begin
            $display("[ERROR] %0s bundle %0d expected %h_%h actual %h_%h",
                     test_name, got, exp1, exp0, act1, act0);
            bad = 1'b1;
          end
        end
        got <= got + 1;
      end
      if (test_done) begin
        if (got != int'(exp_count)) begin
          $display("test %0s did not deliver all of its bundles", test_name);
          bad = 1'b1;
        end
        if (bad) begin
          fail_count <= fail_count + 1;
          $display("FAIL %0s", test_name);
        end else begin
          pass_count <= pass_count + 1;
          $display("PASS %0s", test_name);
        end
      end
    end
  end

endmodule

// File: tests/dual_issue_checker.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module dual_issue_checker (
  input logic                   clk,
  input logic                   arst_n,
  input logic                   flush,
  input logic                   in_ready,
  input logic                   out_valid,
  input logic                   out_ready,
  input logic                   lane0_valid,
  input logic [`INST_WIDTH-1:0] lane0_inst,
  input logic [`ADDR_WIDTH-1:0] lane0_pc,
  input logic [`ID_WIDTH-1:0]   lane0_id,
  input logic                   lane1_valid,
  input logic [`INST_WIDTH-1:0] lane1_inst,
  input logic [`ADDR_WIDTH-1:0] lane1_pc,
  input logic [`ID_WIDTH-1:0]   lane1_id
);

  logic [5:0] op0;
  logic [5:0] op1;
  logic       br0;
  logic       br1;
  int         assert_errors; // failed assertions so far.

  assign op0 = lane0_inst[`OPCODE_MSB:`OPCODE_LSB];
  assign op1 = lane1_inst[`OPCODE_MSB:`OPCODE_LSB];
  assign br0 = (op0[5:4] == 2'b11) || (op0 inside {6'b001110, 6'b001111, 6'b011110, 6'b011111});
  assign br1 = (op1[5:4] == 2'b11) || (op1 inside {6'b001110, 6'b001111, 6'b011110, 6'b011111});

  // held output must not move or change.
  hold_stable: assert property (@(posedge clk) disable iff (!arst_n || flush)
    out_valid && !out_ready |=> out_valid && $stable({lane0_valid, lane0_inst, lane0_pc,
                                                      lane0_id, lane1_valid, lane1_inst,
                                                      lane1_pc, lane1_id}))
    else begin
      $error("output changed while stalled");
      assert_errors = assert_errors + 1;
    end

  lane_rules: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && lane0_valid && lane1_valid |->
      !(br0 && br1) && !(op0[5:4] == 2'b10 && op1[5:4] == 2'b10))
    else begin
      $error("pipe conflict between lanes");
      assert_errors = assert_errors + 1;
    end

  flush_ready: assert property (@(posedge clk) disable iff (!arst_n) flush |-> !in_ready)
    else begin
      $error("in_ready high during flush");
      assert_errors = assert_errors + 1;
    end

endmodule

bind dual_issue dual_issue_checker checker_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .flush       (flush),
  .in_ready    (in_ready),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .lane0_valid (lane0_valid),
  .lane0_inst  (lane0_inst),
  .lane0_pc    (lane0_pc),
  .lane0_id    (lane0_id),
  .lane1_valid (lane1_valid),
  .lane1_inst  (lane1_inst),
  .lane1_pc    (lane1_pc),
  .lane1_id    (lane1_id)
);

// File: source/dual_issue.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module dual_issue
  import issue_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   flush,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  logic [`INST_WIDTH-1:0] inst0,
  input  logic [`INST_WIDTH-1:0] inst1,
  input  logic [`ADDR_WIDTH-1:0] pc0,
  input  logic [`ADDR_WIDTH-1:0] pc1,
  input  logic [`ID_WIDTH-1:0]   id0,
  input  logic [`ID_WIDTH-1:0]   id1,
  output logic                   out_valid,
  input  logic                   out_ready,
  output logic                   lane0_valid,
  output logic [`INST_WIDTH-1:0] lane0_inst,
  output logic [`ADDR_WIDTH-1:0] lane0_pc,
  output logic [`ID_WIDTH-1:0]   lane0_id,
  output logic                   lane1_valid,
  output logic [`INST_WIDTH-1:0] lane1_inst,
  output logic [`ADDR_WIDTH-1:0] lane1_pc,
  output logic [`ID_WIDTH-1:0]   lane1_id
);

  decoded_pair_t dec_pair;
  decoded_pair_t dec_q;
  logic          dec_valid;
  logic          dec_ready;
  issue_bundle_t bundle_d;
  issue_bundle_t bundle_q;
  logic          bundle_valid;
  logic          bundle_ready;

  pair_decode decode_i (
    .inst0 (inst0),
    .inst1 (inst1),
    .pc0   (pc0),
    .pc1   (pc1),
    .id0   (id0),
    .id1   (id1),
    .pair  (dec_pair)
  );

  pipe_reg #(.payload_t(decoded_pair_t)) dec_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (dec_pair),
    .out_valid (dec_valid),
    .out_ready (dec_ready),
    .out_data  (dec_q)
  );

  issue_stage issue_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .flush        (flush),
    .pair_valid   (dec_valid),
    .pair_ready   (dec_ready),
    .pair         (dec_q),
    .bundle_valid (bundle_valid),
    .bundle_ready (bundle_ready),
    .bundle       (bundle_d)
  );

  pipe_reg #(.payload_t(issue_bundle_t)) out_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .flush     (flush),
    .in_valid  (bundle_valid),
    .in_ready  (bundle_ready),
    .in_data   (bundle_d),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (bundle_q)
  );

  ////////////////////////////////////////

  assign lane0_valid = bundle_q.lane0.valid;
  assign lane0_inst  = bundle_q.lane0.inst;
  assign lane0_pc    = bundle_q.lane0.pc;
  assign lane0_id    = bundle_q.lane0.id;
  assign lane1_valid = bundle_q.lane1.valid;
  assign lane1_inst  = bundle_q.lane1.inst;
  assign lane1_pc    = bundle_q.lane1.pc;
  assign lane1_id    = bundle_q.lane1.id;

endmodule

// File: issue/issue_stage.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module issue_stage
  import issue_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  logic          flush,
  input  logic          pair_valid,
  output logic          pair_ready,
  input  decoded_pair_t pair,
  output logic          bundle_valid,
  input  logic          bundle_ready,
  output issue_bundle_t bundle
);

  logic                 held_valid;
  decoded_slot_t        held_slot;
  logic                 last_load_valid;
  logic [`REG_BITS-1:0] last_load_dest;
  decoded_slot_t        head;
  logic                 load_use;
  logic                 split;
  logic                 swap;
  logic                 issue_tail;
  logic                 xfer;
  logic                 load_hit_head;
  logic                 load_hit_tail;

  function automatic issue_lane_t to_lane(input decoded_slot_t s);
    issue_lane_t l;
    l.valid = 1'b1;
    l.inst = s.inst;
    l.pc = s.pc;
    l.id = s.id;
    return l;
  endfunction

  assign head = held_valid ? held_slot : pair.slot0; // held tail goes first.

  hazard_check hazard_i (
    .head            (head),
    .tail            (pair.slot1),
    .tail_present    (!held_valid),
    .last_load_valid (last_load_valid),
    .last_load_dest  (last_load_dest),
    .load_use        (load_use),
    .split           (split),
    .swap            (swap)
  );

  assign issue_tail   = !held_valid && !load_use && !split;
  assign bundle_valid = held_valid || pair_valid;
  assign xfer         = bundle_valid && bundle_ready;
  assign pair_ready   = !held_valid && !load_use && bundle_ready;

  ////////////////////////////////////////

  always_comb begin
    bundle = '0; // bubble when load_use.
    if (!load_use) begin
      if (issue_tail) begin
        bundle.lane0 = swap ? to_lane(pair.slot1) : to_lane(head);
        bundle.lane1 = swap ? to_lane(head) : to_lane(pair.slot1);
      end else if (head.pipe_class == pipe_memory) begin
        bundle.lane1 = to_lane(head);
      end else begin
        bundle.lane0 = to_lane(head);
      end
    end
  end

  // a younger write to the same register hides the load.
  assign load_hit_tail = issue_tail && pair.slot1.is_load;
  assign load_hit_head = head.is_load && !(issue_tail && pair.slot1.reg_use.dest_used &&
                                           pair.slot1.dest == head.dest);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      held_valid      <= 1'b0;
      last_load_valid <= 1'b0;
    end else if (flush) begin
      held_valid      <= 1'b0;
      last_load_valid <= 1'b0;
    end else if (xfer) begin
      held_valid      <= held_valid ? load_use : (!load_use && split);
      last_load_valid <= !load_use && (load_hit_head || load_hit_tail);
    end
  end

  always_ff @(posedge clk) begin
    if (xfer && !held_valid && !load_use && split) begin
      held_slot <= pair.slot1;
    end
    if (xfer) begin
      last_load_dest <= load_hit_tail ? pair.slot1.dest : head.dest;
    end
  end

endmodule

// File: issue/hazard_check.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module hazard_check
  import issue_pkg::*;
(
  input  decoded_slot_t        head,
  input  decoded_slot_t        tail,
  input  logic                 tail_present,
  input  logic                 last_load_valid,
  input  logic [`REG_BITS-1:0] last_load_dest,
  output logic                 load_use,
  output logic                 split,
  output logic                 swap
);

  logic head_src0_hit;
  logic head_src1_hit;
  logic tail_dep;
  logic both_branch;
  logic both_memory;

  ////////////////////////////////////////
  // load-use against the last issued lw

  assign head_src0_hit = head.reg_use.src0_used && (head.src0 == last_load_dest);
  assign head_src1_hit = head.reg_use.src1_used && (head.src1 == last_load_dest);

  assign load_use = last_load_valid && (head_src0_hit || head_src1_hit);

  ////////////////////////////////////////
  // intra-pair dependency and pipe conflict

  always_comb begin
    tail_dep = 1'b0;
    if (head.reg_use.dest_used) begin
      if (tail.reg_use.src0_used && tail.src0 == head.dest) begin
        tail_dep = 1'b1;
      end
      if (tail.reg_use.src1_used && tail.src1 == head.dest) begin
        tail_dep = 1'b1;
      end
    end
  end

  assign both_branch = (head.pipe_class == pipe_branch) && (tail.pipe_class == pipe_branch);
  assign both_memory = (head.pipe_class == pipe_memory) && (tail.pipe_class == pipe_memory);

  assign split = tail_present && (tail_dep || both_branch || both_memory);

  // branch needs lane 0, memory needs lane 1.
  assign swap = (head.pipe_class == pipe_memory) || (tail.pipe_class == pipe_branch);

endmodule

// File: source/pair_decode.sv
`timescale 1ns/1ps

`include "issue_params.svh"

module pair_decode
  import issue_pkg::*;
(
  input  logic [`INST_WIDTH-1:0] inst0,
  input  logic [`INST_WIDTH-1:0] inst1,
  input  logic [`ADDR_WIDTH-1:0] pc0,
  input  logic [`ADDR_WIDTH-1:0] pc1,
  input  logic [`ID_WIDTH-1:0]   id0,
  input  logic [`ID_WIDTH-1:0]   id1,
  output decoded_pair_t          pair
);

  function automatic decoded_slot_t decode_slot(
    input logic [`INST_WIDTH-1:0] inst,
    input logic [`ADDR_WIDTH-1:0] pc,
    input logic [`ID_WIDTH-1:0]   id
  );
    decoded_slot_t s;
    logic [`OPCODE_BITS-1:0] op;
    logic [`REG_BITS-1:0] rs;
    logic [`REG_BITS-1:0] rt;
    logic [`REG_BITS-1:0] rd;
    op = inst[`OPCODE_MSB:`OPCODE_LSB];
    rs = inst[`RS_MSB:`RS_LSB];
    rt = inst[`RT_MSB:`RT_LSB];
    rd = inst[`RD_MSB:`RD_LSB];
    s = '0; // unused register fields stay zero.
    s.inst = inst;
    s.pc = pc;
    s.id = id;
    s.pipe_class = pipe_any;
    casez (op)
      6'b00????: begin // alu register form.
        if (op != `OP_NOP) begin
          s.src0 = rs;
          s.src1 = rt;
          s.dest = rd;
          s.reg_use.src0_used = 1'b1;
          s.reg_use.src1_used = 1'b1;
          s.reg_use.dest_used = 1'b1;
        end
        if (op == `OP_CMP || op == `OP_TEST) begin
          s.pipe_class = pipe_branch;
        end
      end
      6'b01????: begin // alu immediate.
        s.src0 = rs;
        s.dest = rt;
        s.reg_use.src0_used = 1'b1;
        s.reg_use.dest_used = 1'b1;
        if (op == `OP_CMPI || op == `OP_TESTI) begin
          s.pipe_class = pipe_branch;
        end
      end
      6'b10????: begin
        s.pipe_class = pipe_memory;
        if (op == `OP_LW) begin
          s.src0 = rs;
          s.dest = rt;
          s.reg_use.src0_used = 1'b1;
          s.reg_use.dest_used = 1'b1;
          s.is_load = 1'b1;
        end else if (op == `OP_SW) begin
          s.src0 = rs;
          s.src1 = rt; // store data.
          s.reg_use.src0_used = 1'b1;
          s.reg_use.src1_used = 1'b1;
        end
      end
      default: begin // branches.
        s.pipe_class = pipe_branch;
        if (op == `OP_JR) begin
          s.src0 = rs;
          s.reg_use.src0_used = 1'b1;
        end
      end
    endcase
    return s;
  endfunction

  assign pair.slot0 = decode_slot(inst0, pc0, id0);
  assign pair.slot1 = decode_slot(inst1, pc1, id1);

endmodule

// File: source/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     flush,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic run;

  // low through reset and for the first edge after it.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  assign in_ready = run && !flush && (!out_valid || out_ready);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      out_data  <= '0; // keeps lane valids low out of reset.
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
      if (in_valid) begin
        out_data <= in_data;
      end
    end
  end

endmodule

// File: common/issue_pkg.sv
`include "issue_params.svh"

package issue_pkg;

  typedef enum logic [1:0] {
    pipe_any    = 2'd0,
    pipe_branch = 2'd1,
    pipe_memory = 2'd2
  } pipe_class_t;

  typedef struct packed {
    logic src0_used;
    logic src1_used;
    logic dest_used;
  } reg_use_t;

  ////////////////////////////////////////

  typedef struct packed {
    logic [`INST_WIDTH-1:0] inst;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ID_WIDTH-1:0]   id;
    logic [`REG_BITS-1:0]   src0;
    logic [`REG_BITS-1:0]   src1;
    logic [`REG_BITS-1:0]   dest;
    reg_use_t               reg_use;
    pipe_class_t            pipe_class;
    logic                   is_load;
  } decoded_slot_t;

  typedef struct packed {
    decoded_slot_t slot1;
    decoded_slot_t slot0; // older instruction.
  } decoded_pair_t;

  ////////////////////////////////////////

  typedef struct packed {
    logic                   valid;
    logic [`INST_WIDTH-1:0] inst;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ID_WIDTH-1:0]   id;
  } issue_lane_t;

  typedef struct packed {
    issue_lane_t lane1; // memory and alu.
    issue_lane_t lane0; // branch and alu.
  } issue_bundle_t;

endpackage

// File: common/issue_params.svh
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

`define INST_WIDTH  32
`define ADDR_WIDTH  16
`define ID_WIDTH    4
`define REG_BITS    5
`define OPCODE_BITS 6

`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11

`define OP_NOP   6'b000000
`define OP_LW    6'b100000
`define OP_SW    6'b100001
`define OP_JR    6'b110001
`define OP_CMP   6'b001110 // flag writers go down the branch pipe.
`define OP_TEST  6'b001111
`define OP_CMPI  6'b011110
`define OP_TESTI 6'b011111

`endif
